// ==== hdl/isa_pkg.sv ====
// RV32IM base encodings only; no compressed, FENCE, ECALL or CSR immediate forms
package isa_pkg;

    ////////////////////
    // instruction layout

    // r-type view, other formats reuse these positions
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef union packed {
        logic [31:0] raw;
        r_type_t     r;
    } inst_t;

    ////////////////////
    // opcodes

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    ////////////////////
    // function codes

    // integer alu, shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // m extension, multiply half only
    localparam logic [2:0] F3_MUL     = 3'b000;
    localparam logic [2:0] F3_MULH    = 3'b001;
    localparam logic [2:0] F3_MULHSU  = 3'b010;
    localparam logic [2:0] F3_MULHU   = 3'b011;
    // control flow
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;
    // memory widths
    localparam logic [2:0] F3_LB      = 3'b000;
    localparam logic [2:0] F3_LH      = 3'b001;
    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_LBU     = 3'b100;
    localparam logic [2:0] F3_LHU     = 3'b101;
    localparam logic [2:0] F3_SB      = 3'b000;
    localparam logic [2:0] F3_SH      = 3'b001;
    localparam logic [2:0] F3_SW      = 3'b010;
    // csr access
    localparam logic [2:0] F3_CSRRW   = 3'b001;
    localparam logic [2:0] F3_CSRRS   = 3'b010;
    localparam logic [2:0] F3_CSRRC   = 3'b011;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    // wfi doubles as halt
    localparam logic [31:0] WFI = 32'h1050_0073;

    ////////////////////
    // datapath selects

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
    } alu_func_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1, OPA_IS_PC, OPA_IS_ZERO
    } opa_sel_e;

    typedef enum logic [3:0] {
        OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM, OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
    } opb_sel_e;

endpackage

// ==== hdl/dispatch_pkg.sv ====
// single-issue dispatch types; ROB_TAG_W fixes the ROB at 32 entries
package dispatch_pkg;
    import isa_pkg::*;

    localparam int XLEN = 32;

    typedef logic [4:0] reg_idx_t;
    localparam reg_idx_t ZERO_REG = 5'd0;

    localparam int ROB_TAG_W = 5;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    ////////////////////
    // packets

    // from the instruction buffer
    typedef struct packed {
        inst_t           inst;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] npc;
    } fetch_packet_t;

    // dest_reg_idx is ZERO_REG for anything that writes no register
    typedef struct packed {
        inst_t           inst;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] npc;
        opa_sel_e        opa_select;
        opb_sel_e        opb_select;
        alu_func_e       alu_func;
        reg_idx_t        dest_reg_idx;
        logic            rd_mem;
        logic            wr_mem;
        logic            cond_branch;
        logic            uncond_branch;
        logic            csr_op;
        logic            halt;
        logic            illegal;
    } decoded_packet_t;

    // architectural writeback, no handshake
    typedef struct packed {
        logic            en;
        reg_idx_t        idx;
        logic [XLEN-1:0] data;
    } wb_packet_t;

    // producer tag, meaningless unless valid
    typedef struct packed {
        rob_tag_t tag;
        logic     valid;
    } src_tag_t;

    // to the reservation station and the ROB
    typedef struct packed {
        decoded_packet_t decoded;
        logic [XLEN-1:0] rs1_value;
        logic [XLEN-1:0] rs2_value;
        src_tag_t        rs1_tag;
        src_tag_t        rs2_tag;
    } dispatch_packet_t;

endpackage

// ==== hdl/inst_decoder.sv ====
// combinational only; division, FENCE, ECALL and CSR immediate forms decode as illegal
module inst_decoder
    import isa_pkg::*;
    import dispatch_pkg::*;
(
    input  inst_t           inst,
    input  logic            valid,
    input  fetch_packet_t   fetch,
    output decoded_packet_t decoded
);

    logic      has_dest;
    alu_func_e base_func;
    alu_func_e mul_func;

    ////////////////////
    // function fields

    // bit 30 picks sub and sra, addi overrides it below
    always_comb begin
        case (inst.r.funct3)
            F3_ADD_SUB: base_func = inst.r.funct7[5] ? ALU_SUB : ALU_ADD;
            F3_SLL:     base_func = ALU_SLL;
            F3_SLT:     base_func = ALU_SLT;
            F3_SLTU:    base_func = ALU_SLTU;
            F3_XOR:     base_func = ALU_XOR;
            F3_SRL_SRA: base_func = inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:      base_func = ALU_OR;
            default:    base_func = ALU_AND;
        endcase
    end

    always_comb begin
        case (inst.r.funct3)
            F3_MUL:    mul_func = ALU_MUL;
            F3_MULH:   mul_func = ALU_MULH;
            F3_MULHSU: mul_func = ALU_MULHSU;
            default:   mul_func = ALU_MULHU;
        endcase
    end

    ////////////////////
    // opcode match

    always_comb begin
        // nop defaults, also the invalid case
        decoded.inst          = inst;
        decoded.pc            = fetch.pc;
        decoded.npc           = fetch.npc;
        decoded.opa_select    = OPA_IS_RS1;
        decoded.opb_select    = OPB_IS_RS2;
        decoded.alu_func      = ALU_ADD;
        decoded.rd_mem        = 1'b0;
        decoded.wr_mem        = 1'b0;
        decoded.cond_branch   = 1'b0;
        decoded.uncond_branch = 1'b0;
        decoded.csr_op        = 1'b0;
        decoded.halt          = 1'b0;
        decoded.illegal       = 1'b0;
        has_dest              = 1'b0;
        if (valid) begin
            case (inst.r.opcode)
                OPC_LUI, OPC_AUIPC: begin
                    has_dest           = 1'b1;
                    decoded.opa_select = inst.r.opcode[5] ? OPA_IS_ZERO : OPA_IS_PC;
                    decoded.opb_select = OPB_IS_U_IMM;
                end
                OPC_JAL: begin
                    has_dest              = 1'b1;
                    decoded.opa_select    = OPA_IS_PC;
                    decoded.opb_select    = OPB_IS_J_IMM;
                    decoded.uncond_branch = 1'b1;
                end
                OPC_JALR: begin
                    has_dest              = 1'b1;
                    decoded.opb_select    = OPB_IS_I_IMM;
                    decoded.uncond_branch = 1'b1;
                    decoded.illegal       = inst.r.funct3 != F3_JALR;
                end
                OPC_BRANCH: begin
                    decoded.opa_select  = OPA_IS_PC;
                    decoded.opb_select  = OPB_IS_B_IMM;
                    decoded.cond_branch = 1'b1;
                    decoded.illegal     = !(inst.r.funct3 inside
                        {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU});
                end
                OPC_LOAD: begin
                    has_dest           = 1'b1;
                    decoded.opb_select = OPB_IS_I_IMM;
                    decoded.rd_mem     = 1'b1;
                    decoded.illegal    = !(inst.r.funct3 inside
                        {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU});
                end
                OPC_STORE: begin
                    decoded.opb_select = OPB_IS_S_IMM;
                    decoded.wr_mem     = 1'b1;
                    decoded.illegal    = !(inst.r.funct3 inside {F3_SB, F3_SH, F3_SW});
                end
                OPC_OP_IMM: begin
                    has_dest           = 1'b1;
                    decoded.opb_select = OPB_IS_I_IMM;
                    decoded.alu_func   = (inst.r.funct3 == F3_ADD_SUB) ? ALU_ADD : base_func;
                    // shifts keep the upper immediate as a function code
                    if (inst.r.funct3 == F3_SLL) begin
                        decoded.illegal = inst.r.funct7 != F7_BASE;
                    end else if (inst.r.funct3 == F3_SRL_SRA) begin
                        decoded.illegal = !(inst.r.funct7 inside {F7_BASE, F7_ALT});
                    end
                end
                OPC_OP: begin
                    has_dest = 1'b1;
                    case (inst.r.funct7)
                        F7_BASE: decoded.alu_func = base_func;
                        F7_ALT: begin
                            decoded.alu_func = base_func;
                            decoded.illegal  = !(inst.r.funct3 inside {F3_ADD_SUB, F3_SRL_SRA});
                        end
                        F7_MULDIV: begin
                            decoded.alu_func = mul_func;
                            // upper half is div and rem
                            decoded.illegal  = inst.r.funct3[2];
                        end
                        default: decoded.illegal = 1'b1;
                    endcase
                end
                OPC_SYSTEM: begin
                    if (inst == WFI) begin
                        decoded.halt = 1'b1;
                    end else if (inst.r.funct3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC}) begin
                        decoded.csr_op = 1'b1;
                    end else begin
                        decoded.illegal = 1'b1;
                    end
                end
                default: decoded.illegal = 1'b1;
            endcase
        end
        // illegal encodings never claim a destination
        decoded.dest_reg_idx = (has_dest && !decoded.illegal) ? inst.r.rd : ZERO_REG;
    end

endmodule

// ==== hdl/decode_fifo.sv ====
// registered FIFO without bypass so a push shows at the head one cycle later; DEPTH >= 1
module decode_fifo
    import dispatch_pkg::*;
#(
    parameter int DEPTH = 2
) (
    input  logic            clock,
    input  logic            reset,
    input  decoded_packet_t push_data,
    input  logic            push_valid,
    output logic            push_ready,
    output decoded_packet_t head_data,
    output logic            head_valid,
    input  logic            head_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0]   FULL = (PTR_W + 1)'(DEPTH);

    decoded_packet_t  entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    // ready is plain not-full
    assign push_ready = count != FULL;
    assign head_valid = count != '0;
    assign head_data  = entries[rd_ptr];
    assign push       = push_valid && push_ready;
    assign pop        = head_valid && head_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    // pointers wrap at DEPTH rather than at a power of two
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
        end
    end

    // overflow or underflow would leave count and pointers out of step
    assert property (@(posedge clock) disable iff (reset)
        (count == '0 || count == FULL) |-> wr_ptr == rd_ptr);

endmodule

// ==== hdl/reg_file.sv ====
// x0 reads zero and drops writes; a writeback in the same cycle is forwarded to both reads
module reg_file
    import dispatch_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  reg_idx_t        rs1_idx,
    input  reg_idx_t        rs2_idx,
    input  wb_packet_t      wb,
    output logic [XLEN-1:0] rs1_value,
    output logic [XLEN-1:0] rs2_value
);

    // x1..x31, x0 is hardwired
    logic [XLEN-1:0] regs [1:31];

    function automatic logic [XLEN-1:0] read_reg(reg_idx_t idx);
        if (idx == ZERO_REG) begin
            return '0;
        end
        // internal forwarding
        if (wb.en && wb.idx == idx) begin
            return wb.data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_value = read_reg(rs1_idx);
    end

    always_comb begin
        rs2_value = read_reg(rs2_idx);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.idx != ZERO_REG) begin
            regs[wb.idx] <= wb.data;
        end
    end

endmodule

// ==== hdl/rename_map.sv ====
// newest ROB tag per register; entries are not cleared on retire, only by reset
module rename_map
    import dispatch_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  reg_idx_t lookup1_idx,
    input  reg_idx_t lookup2_idx,
    output src_tag_t lookup1,
    output src_tag_t lookup2,
    input  logic     rename_en,
    input  reg_idx_t rename_idx,
    input  rob_tag_t rename_tag
);

    // entry 0 stays invalid, so x0 sources never wait
    src_tag_t entries [32];

    // lookups see the table before this cycle's rename
    assign lookup1 = entries[lookup1_idx];
    assign lookup2 = entries[lookup2_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                entries[i] <= '0;
            end
        end else if (rename_en) begin
            entries[rename_idx].tag   <= rename_tag;
            entries[rename_idx].valid <= 1'b1;
        end
    end

    // the operand stage filters x0 destinations
    assert property (@(posedge clock) disable iff (reset)
        rename_en |-> rename_idx != ZERO_REG);

endmodule

// ==== hdl/operand_fetch.sv ====
// combinational from FIFO head to output; rob_tail must hold while a hand-off is pending
module operand_fetch
    import isa_pkg::*;
    import dispatch_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  decoded_packet_t  head,
    input  logic             head_valid,
    output logic             head_ready,
    output dispatch_packet_t out,
    output logic             out_valid,
    input  logic             out_ready,
    input  rob_tag_t         rob_tail,
    input  wb_packet_t       wb
);

    logic            rename_en;
    logic [XLEN-1:0] rs1_value;
    logic [XLEN-1:0] rs2_value;
    src_tag_t        rs1_lookup;
    src_tag_t        rs2_lookup;

    ////////////////////
    // handshake and rename

    assign out_valid  = head_valid;
    assign head_ready = out_ready;
    // rename at the hand-off edge, x0 and non-writers carry ZERO_REG
    assign rename_en  = head_valid && out_ready && (head.dest_reg_idx != ZERO_REG);

    reg_file regs_i (
        .clock     (clock),
        .reset     (reset),
        .rs1_idx   (head.inst.r.rs1),
        .rs2_idx   (head.inst.r.rs2),
        .wb        (wb),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    rename_map rename_i (
        .clock       (clock),
        .reset       (reset),
        .lookup1_idx (head.inst.r.rs1),
        .lookup2_idx (head.inst.r.rs2),
        .lookup1     (rs1_lookup),
        .lookup2     (rs2_lookup),
        .rename_en   (rename_en),
        .rename_idx  (head.dest_reg_idx),
        .rename_tag  (rob_tail)
    );

    ////////////////////
    // packet

    // pc and immediate operands have no producer
    assign out = '{
        decoded:   head,
        rs1_value: rs1_value,
        rs2_value: rs2_value,
        rs1_tag:   (head.opa_select == OPA_IS_RS1) ? rs1_lookup : '0,
        rs2_tag:   (head.opb_select == OPB_IS_RS2) ? rs2_lookup : '0
    };

    // stalled packet holds, values may only move through a writeback
    assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> $stable(out.decoded) && $stable(out.rs1_tag)
            && $stable(out.rs2_tag) && (wb.en || $stable(out)));

endmodule

// ==== hdl/dispatch_top.sv ====
// single-issue dispatch; earliest exit is one cycle after acceptance, FIFO_DEPTH >= 1
module dispatch_top
    import dispatch_pkg::*;
#(
    parameter int FIFO_DEPTH = 2
) (
    input  logic             clock,
    input  logic             reset,
    input  fetch_packet_t    fetch,
    input  logic             in_valid,
    output logic             in_ready,
    output dispatch_packet_t out,
    output logic             out_valid,
    input  logic             out_ready,
    input  rob_tag_t         rob_tail,
    input  wb_packet_t       wb
);

    decoded_packet_t decoded;
    decoded_packet_t head;
    logic            head_valid;
    logic            head_ready;

    // valid bypasses the decoder, ready is the FIFO's not-full
    inst_decoder decoder_i (
        .inst    (fetch.inst),
        .valid   (in_valid),
        .fetch   (fetch),
        .decoded (decoded)
    );

    decode_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clock      (clock),
        .reset      (reset),
        .push_data  (decoded),
        .push_valid (in_valid),
        .push_ready (in_ready),
        .head_data  (head),
        .head_valid (head_valid),
        .head_ready (head_ready)
    );

    operand_fetch operand_i (
        .clock      (clock),
        .reset      (reset),
        .head       (head),
        .head_valid (head_valid),
        .head_ready (head_ready),
        .out        (out),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .rob_tail   (rob_tail),
        .wb         (wb)
    );

endmodule

// ==== dv/dispatch_tb.sv ====
// directed tests only; needs FIFO_DEPTH >= 2, and the ROB model here holds rob_tail during a hand-off
module dispatch_tb
    import isa_pkg::*;
    import dispatch_pkg::*;
();

    localparam int FIFO_DEPTH = 2;
    // about 27 instructions, each done within 6 cycles, plus stalls and writes
    localparam int INST_COUNT      = 30;
    localparam int CYCLES_PER_INST = 6;
    localparam int TIMEOUT_CYCLES  = INST_COUNT * CYCLES_PER_INST + 100;

    // flag order rd_mem, wr_mem, cond, uncond, csr, halt, illegal
    localparam logic [6:0] F_NONE    = 7'b0000000;
    localparam logic [6:0] F_RD_MEM  = 7'b1000000;
    localparam logic [6:0] F_WR_MEM  = 7'b0100000;
    localparam logic [6:0] F_COND    = 7'b0010000;
    localparam logic [6:0] F_UNCOND  = 7'b0001000;
    localparam logic [6:0] F_CSR     = 7'b0000100;
    localparam logic [6:0] F_HALT    = 7'b0000010;
    localparam logic [6:0] F_ILLEGAL = 7'b0000001;

    logic             clock;
    logic             reset;
    fetch_packet_t    fetch;
    logic             in_valid;
    logic             in_ready;
    dispatch_packet_t out;
    logic             out_valid;
    logic             out_ready;
    rob_tag_t         rob_tail;
    wb_packet_t       wb;
    int               cycles = 0;
    integer           seed = 32'had8b;
    logic [31:0]      pc_counter = 32'h0000_1000;

    dispatch_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut_i (
        .clock     (clock),
        .reset     (reset),
        .fetch     (fetch),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out       (out),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .rob_tail  (rob_tail),
        .wb        (wb)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // watchdog
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped handing off", cycles);
            abort();
        end
    end

    ////////////////////
    // reporting

    task automatic abort();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            abort();
        end
    endtask

    ////////////////////
    // instruction builders

    // also covers s and b forms, funct7 and rd carry the immediate bits
    function automatic logic [31:0] r_inst(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
            logic [2:0] f3, reg_idx_t rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_inst(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
            reg_idx_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_inst(logic [19:0] imm, reg_idx_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    ////////////////////
    // bus drivers

    // all drivers start and end just after a falling edge
    task automatic push_inst(logic [31:0] bits);
        fetch.inst.raw = bits;
        fetch.pc       = pc_counter;
        fetch.npc      = pc_counter + 32'd4;
        in_valid       = 1'b1;
        while (!in_ready) @(negedge clock);
        // accepted on the rising edge in between
        @(negedge clock);
        in_valid   = 1'b0;
        pc_counter = pc_counter + 32'd4;
    endtask

    task automatic pop_packet(rob_tag_t tail, wb_packet_t wb_in, output dispatch_packet_t pkt);
        while (!out_valid) @(negedge clock);
        rob_tail  = tail;
        wb        = wb_in;
        out_ready = 1'b1;
        // settle time for the forwarding path
        #2;
        pkt = out;
        @(negedge clock);
        out_ready = 1'b0;
        wb        = '0;
    endtask

    task automatic dispatch_inst(logic [31:0] bits, rob_tag_t tail,
            output dispatch_packet_t pkt);
        push_inst(bits);
        pop_packet(tail, '0, pkt);
    endtask

    task automatic write_reg(reg_idx_t idx, logic [31:0] data);
        wb = '{en: 1'b1, idx: idx, data: data};
        @(negedge clock);
        wb = '0;
    endtask

    ////////////////////
    // tests

    task automatic expect_decode(string name, logic [31:0] bits, opa_sel_e opa, opb_sel_e opb,
            alu_func_e alu, reg_idx_t dest, logic [6:0] flags);
        dispatch_packet_t pkt;
        logic [31:0]      pc;
        pc = pc_counter;
        dispatch_inst(bits, 5'd3, pkt);
        check({name, " inst"}, bits, pkt.decoded.inst);
        check({name, " pc"}, pc, pkt.decoded.pc);
        check({name, " npc"}, pc + 32'd4, pkt.decoded.npc);
        check({name, " opa_select"}, opa, pkt.decoded.opa_select);
        check({name, " opb_select"}, opb, pkt.decoded.opb_select);
        check({name, " alu_func"}, alu, pkt.decoded.alu_func);
        check({name, " dest_reg_idx"}, dest, pkt.decoded.dest_reg_idx);
        check({name, " flags"}, flags, {pkt.decoded.rd_mem, pkt.decoded.wr_mem,
            pkt.decoded.cond_branch, pkt.decoded.uncond_branch, pkt.decoded.csr_op,
            pkt.decoded.halt, pkt.decoded.illegal});
    endtask

    // destinations x20 and up, kept clear of the rename tests
    task automatic decoding();
        expect_decode("addi", i_inst(12'h123, 5'd3, F3_ADD_SUB, 5'd20, OPC_OP_IMM),
            OPA_IS_RS1, OPB_IS_I_IMM, ALU_ADD, 5'd20, F_NONE);
        expect_decode("sub", r_inst(F7_ALT, 5'd4, 5'd3, F3_ADD_SUB, 5'd21, OPC_OP),
            OPA_IS_RS1, OPB_IS_RS2, ALU_SUB, 5'd21, F_NONE);
        expect_decode("mulhu", r_inst(F7_MULDIV, 5'd4, 5'd3, F3_MULHU, 5'd22, OPC_OP),
            OPA_IS_RS1, OPB_IS_RS2, ALU_MULHU, 5'd22, F_NONE);
        expect_decode("lui", u_inst(20'habcde, 5'd23, OPC_LUI),
            OPA_IS_ZERO, OPB_IS_U_IMM, ALU_ADD, 5'd23, F_NONE);
        expect_decode("auipc", u_inst(20'h00010, 5'd24, OPC_AUIPC),
            OPA_IS_PC, OPB_IS_U_IMM, ALU_ADD, 5'd24, F_NONE);
        expect_decode("jal", u_inst(20'h00800, 5'd25, OPC_JAL),
            OPA_IS_PC, OPB_IS_J_IMM, ALU_ADD, 5'd25, F_UNCOND);
        expect_decode("jalr", i_inst(12'h010, 5'd3, F3_JALR, 5'd26, OPC_JALR),
            OPA_IS_RS1, OPB_IS_I_IMM, ALU_ADD, 5'd26, F_UNCOND);
        // branch and store rd fields hold immediate bits
        expect_decode("bne", r_inst(7'h00, 5'd4, 5'd3, F3_BNE, 5'd8, OPC_BRANCH),
            OPA_IS_PC, OPB_IS_B_IMM, ALU_ADD, ZERO_REG, F_COND);
        expect_decode("lw", i_inst(12'h004, 5'd3, F3_LW, 5'd27, OPC_LOAD),
            OPA_IS_RS1, OPB_IS_I_IMM, ALU_ADD, 5'd27, F_RD_MEM);
        expect_decode("sw", r_inst(7'h00, 5'd4, 5'd3, F3_SW, 5'd8, OPC_STORE),
            OPA_IS_RS1, OPB_IS_S_IMM, ALU_ADD, ZERO_REG, F_WR_MEM);
        // csrw mscratch, x3
        expect_decode("csrrw", i_inst(12'h340, 5'd3, F3_CSRRW, ZERO_REG, OPC_SYSTEM),
            OPA_IS_RS1, OPB_IS_RS2, ALU_ADD, ZERO_REG, F_CSR);
        expect_decode("wfi", WFI, OPA_IS_RS1, OPB_IS_RS2, ALU_ADD, ZERO_REG, F_HALT);
        expect_decode("undefined", r_inst(7'h00, 5'd4, 5'd3, 3'b000, 5'd29, 7'b1111111),
            OPA_IS_RS1, OPB_IS_RS2, ALU_ADD, ZERO_REG, F_ILLEGAL);
    endtask

    task automatic register_access();
        dispatch_packet_t pkt;
        logic [31:0]      v1;
        logic [31:0]      v2;
        logic [31:0]      v3;
        logic [31:0]      v4;
        v1 = $random(seed);
        v2 = $random(seed);
        v3 = $random(seed);
        v4 = $random(seed);
        write_reg(5'd5, v1);
        write_reg(5'd6, v2);
        dispatch_inst(r_inst(F7_BASE, 5'd6, 5'd5, F3_ADD_SUB, 5'd8, OPC_OP), 5'd4, pkt);
        check("rs1_value", v1, pkt.rs1_value);
        check("rs2_value", v2, pkt.rs2_value);
        // write lands in the same cycle as the read
        push_inst(r_inst(F7_BASE, ZERO_REG, 5'd10, F3_ADD_SUB, 5'd9, OPC_OP));
        pop_packet(5'd5, '{en: 1'b1, idx: 5'd10, data: v3}, pkt);
        check("forwarded rs1_value", v3, pkt.rs1_value);
        check("x0 rs2_value", 32'd0, pkt.rs2_value);
        write_reg(ZERO_REG, v4);
        dispatch_inst(r_inst(F7_BASE, ZERO_REG, ZERO_REG, F3_ADD_SUB, 5'd11, OPC_OP),
            5'd6, pkt);
        check("x0 rs1_value", 32'd0, pkt.rs1_value);
        check("x0 rs2_value", 32'd0, pkt.rs2_value);
    endtask

    task automatic rename_tags();
        dispatch_packet_t pkt;
        // both in the FIFO before the first hand-off
        push_inst(r_inst(F7_BASE, 5'd4, 5'd3, F3_ADD_SUB, 5'd7, OPC_OP));
        push_inst(r_inst(F7_BASE, 5'd2, 5'd7, F3_ADD_SUB, 5'd1, OPC_OP));
        pop_packet(5'd9, '0, pkt);
        pop_packet(5'd10, '0, pkt);
        check("rs1_tag", {5'd9, 1'b1}, pkt.rs1_tag);
        check("rs2_tag.valid", 1'b0, pkt.rs2_tag.valid);
        // immediate bits 4:0 point at x7
        dispatch_inst(i_inst(12'h007, 5'd7, F3_ADD_SUB, 5'd12, OPC_OP_IMM), 5'd11, pkt);
        check("addi rs1_tag", {5'd9, 1'b1}, pkt.rs1_tag);
        check("addi rs2_tag", 6'd0, pkt.rs2_tag);
    endtask

    task automatic map_untouched();
        dispatch_packet_t pkt;
        dispatch_inst(r_inst(F7_BASE, 5'd4, 5'd3, F3_ADD_SUB, ZERO_REG, OPC_OP), 5'd15, pkt);
        // rd field of 7 must not rename x7
        dispatch_inst(r_inst(7'h00, 5'd4, 5'd3, F3_SW, 5'd7, OPC_STORE), 5'd16, pkt);
        dispatch_inst(r_inst(7'h00, 5'd4, 5'd3, F3_BNE, 5'd7, OPC_BRANCH), 5'd17, pkt);
        dispatch_inst(r_inst(F7_BASE, 5'd7, ZERO_REG, F3_ADD_SUB, 5'd13, OPC_OP), 5'd18, pkt);
        check("x0 rs1_tag", 6'd0, pkt.rs1_tag);
        check("x7 rs2_tag", {5'd9, 1'b1}, pkt.rs2_tag);
    endtask

    task automatic back_pressure();
        dispatch_packet_t pkt;
        dispatch_packet_t held;
        logic [31:0]      sent [FIFO_DEPTH];
        // chain, each reads the previous destination
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            sent[i] = r_inst(F7_BASE, ZERO_REG, reg_idx_t'(14 + i), F3_ADD_SUB,
                reg_idx_t'(15 + i), OPC_OP);
            check("in_ready before fill", 1'b1, in_ready);
            push_inst(sent[i]);
        end
        check("in_ready when full", 1'b0, in_ready);
        check("out_valid when full", 1'b1, out_valid);
        held = out;
        repeat (3) @(negedge clock);
        check("stalled out unchanged", 1'b1, out === held);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            pop_packet(rob_tag_t'(20 + i), '0, pkt);
            check("drained inst", sent[i], pkt.decoded.inst);
            if (i > 0) begin
                check("chained rs1_tag", {rob_tag_t'(19 + i), 1'b1}, pkt.rs1_tag);
            end
        end
        dispatch_inst(r_inst(F7_BASE, ZERO_REG, reg_idx_t'(14 + FIFO_DEPTH), F3_ADD_SUB,
            5'd30, OPC_OP), 5'd31, pkt);
        check("last rs1_tag", {rob_tag_t'(19 + FIFO_DEPTH), 1'b1}, pkt.rs1_tag);
    endtask

    ////////////////////
    // sequence

    initial begin
        reset     = 1'b1;
        fetch     = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        rob_tail  = '0;
        wb        = '0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        check("in_ready after reset", 1'b1, in_ready);
        check("out_valid after reset", 1'b0, out_valid);
        decoding();
        register_access();
        rename_tags();
        map_untouched();
        back_pressure();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== files.f ====
hdl/isa_pkg.sv
hdl/dispatch_pkg.sv
hdl/inst_decoder.sv
hdl/decode_fifo.sv
hdl/reg_file.sv
hdl/rename_map.sv
hdl/operand_fetch.sv
hdl/dispatch_top.sv
dv/dispatch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= dispatch_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
